/* src/cnn_pkg.sv */
package cnn_pkg;

  // array geometry
  localparam int COLS          = 4;
  localparam int WEIGHTS_DEPTH = 16;

  // signed pixel and weight width
  localparam int WORD_WIDTH = 8;

  // holds 16 full-scale products without overflow
  localparam int ACC_WIDTH = 20;

  // weight memory read latency in clkb cycles
  localparam int LATENCY_BRAM = 2;

  // one wide row carries a weight per column
  localparam int ROW_WIDTH = COLS * WORD_WIDTH;

  // narrow write words
  localparam int W_DEPTH = WEIGHTS_DEPTH * COLS;

  localparam int W_ADDR_WIDTH = $clog2(W_DEPTH);
  localparam int R_ADDR_WIDTH = $clog2(WEIGHTS_DEPTH);

  localparam int COL_WIDTH = $clog2(COLS);

  // countdown that keeps the read pipeline moving after a pixel
  localparam int FLUSH_WIDTH = $clog2(LATENCY_BRAM + 1);

  // signed product of one pixel and one weight
  localparam int PROD_WIDTH = 2 * WORD_WIDTH;

endpackage

/* src/ram_raw.sv */
module ram_raw #(
  parameter int LATENCY = cnn_pkg::LATENCY_BRAM
) (
  input  logic                             clkb,
  input  logic                             reset,
  input  logic                             wr_en,
  input  logic [cnn_pkg::W_ADDR_WIDTH-1:0] wr_addr,
  input  logic [cnn_pkg::WORD_WIDTH-1:0]   wr_data,
  input  logic                             rd_en,
  input  logic [cnn_pkg::R_ADDR_WIDTH-1:0] rd_addr,
  output logic [cnn_pkg::ROW_WIDTH-1:0]    rd_row
);

  // narrow view for writes
  logic [cnn_pkg::W_DEPTH-1:0][cnn_pkg::WORD_WIDTH-1:0] mem;

  // same bits seen as wide rows, column 0 in the low slice
  logic [cnn_pkg::WEIGHTS_DEPTH-1:0][cnn_pkg::ROW_WIDTH-1:0] mem_rows;

  logic [LATENCY-1:0][cnn_pkg::ROW_WIDTH-1:0] rd_pipe;

  assign mem_rows = mem;

  always_ff @(posedge clkb) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read pipeline only moves while rd_en is high
  always_ff @(posedge clkb) begin
    if (reset) begin
      rd_pipe <= '0;
    end else if (rd_en) begin
      rd_pipe[0] <= mem_rows[rd_addr];
      for (int i = 1; i < LATENCY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign rd_row = rd_pipe[LATENCY-1];

endmodule

/* src/mac_feeder.sv */
module mac_feeder (
  input  logic                                  clkb,
  input  logic                                  reset,
  input  logic                                  px_valid,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] px_data,
  input  logic                                  px_last,
  output logic                                  rd_en,
  output logic [cnn_pkg::R_ADDR_WIDTH-1:0]      rd_addr,
  output logic                                  mac_valid,
  output logic signed [cnn_pkg::WORD_WIDTH-1:0] mac_pixel,
  output logic                                  mac_last
);

  // position inside the current window, also the weight row
  logic [cnn_pkg::R_ADDR_WIDTH-1:0] win_cnt;

  logic [cnn_pkg::FLUSH_WIDTH-1:0] flush_cnt;

  // delay line matched to the memory latency
  logic [cnn_pkg::LATENCY_BRAM-1:0]                         vld_dly;
  logic [cnn_pkg::LATENCY_BRAM-1:0]                         last_dly;
  logic [cnn_pkg::LATENCY_BRAM-1:0][cnn_pkg::WORD_WIDTH-1:0] pix_dly;

  always_ff @(posedge clkb) begin
    if (reset) begin
      win_cnt <= '0;
    end else if (px_valid) begin
      if (px_last) begin
        win_cnt <= '0;
      end else begin
        win_cnt <= win_cnt + 1'b1;
      end
    end
  end

  assign rd_addr = win_cnt;

  // keep rd_en up until the row of the latest pixel has left the memory
  always_ff @(posedge clkb) begin
    if (reset) begin
      flush_cnt <= '0;
    end else if (px_valid) begin
      flush_cnt <= cnn_pkg::FLUSH_WIDTH'(cnn_pkg::LATENCY_BRAM);
    end else if (flush_cnt != '0) begin
      flush_cnt <= flush_cnt - 1'b1;
    end
  end

  assign rd_en = px_valid || (flush_cnt != '0);

  always_ff @(posedge clkb) begin
    if (reset) begin
      vld_dly  <= '0;
      last_dly <= '0;
    end else begin
      vld_dly[0]  <= px_valid;
      last_dly[0] <= px_valid && px_last;
      for (int i = 1; i < cnn_pkg::LATENCY_BRAM; i++) begin
        vld_dly[i]  <= vld_dly[i-1];
        last_dly[i] <= last_dly[i-1];
      end
    end
  end

  always_ff @(posedge clkb) begin
    pix_dly[0] <= px_data;
    for (int i = 1; i < cnn_pkg::LATENCY_BRAM; i++) begin
      pix_dly[i] <= pix_dly[i-1];
    end
  end

  assign mac_valid = vld_dly[cnn_pkg::LATENCY_BRAM-1];
  assign mac_last  = last_dly[cnn_pkg::LATENCY_BRAM-1];
  assign mac_pixel = pix_dly[cnn_pkg::LATENCY_BRAM-1];

endmodule

/* src/mac_pe.sv */
module mac_pe (
  input  logic                                  clkb,
  input  logic                                  reset,
  input  logic                                  mac_valid,
  input  logic                                  mac_last,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] mac_pixel,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] weight,
  output logic                                  sum_valid,
  output logic signed [cnn_pkg::ACC_WIDTH-1:0]  sum
);

  logic signed [cnn_pkg::PROD_WIDTH-1:0] prod;
  logic signed [cnn_pkg::ACC_WIDTH-1:0]  acc;
  logic signed [cnn_pkg::ACC_WIDTH-1:0]  acc_next;

  assign prod     = mac_pixel * weight;
  // prod is sign extended to the accumulator width
  assign acc_next = acc + prod;

  always_ff @(posedge clkb) begin
    if (reset) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= mac_valid && mac_last;
      if (mac_valid) begin
        // restart from zero once the window closes
        acc <= mac_last ? '0 : acc_next;
      end
    end
  end

  always_ff @(posedge clkb) begin
    if (mac_valid && mac_last) begin
      sum <= acc_next;
    end
  end

endmodule

/* src/result_drain.sv */
module result_drain (
  input  logic                                             clkb,
  input  logic                                             reset,
  input  logic                                             sum_valid,
  input  logic [cnn_pkg::COLS-1:0][cnn_pkg::ACC_WIDTH-1:0] sums,
  output logic                                             res_valid,
  output logic [cnn_pkg::COL_WIDTH-1:0]                    res_col,
  output logic signed [cnn_pkg::ACC_WIDTH-1:0]             res_data
);

  // snapshot of all columns, read out one per cycle
  logic [cnn_pkg::COLS-1:0][cnn_pkg::ACC_WIDTH-1:0] sums_q;

  logic [cnn_pkg::COL_WIDTH-1:0] next_col;
  logic                          last_col;

  assign next_col = res_col + 1'b1;
  assign last_col = (res_col == cnn_pkg::COL_WIDTH'(cnn_pkg::COLS - 1));

  always_ff @(posedge clkb) begin
    if (reset) begin
      res_valid <= 1'b0;
      res_col   <= '0;
    end else if (sum_valid) begin
      res_valid <= 1'b1;
      res_col   <= '0;
    end else if (res_valid) begin
      if (last_col) begin
        res_valid <= 1'b0;
        res_col   <= '0;
      end else begin
        res_col <= next_col;
      end
    end
  end

  always_ff @(posedge clkb) begin
    if (sum_valid) begin
      sums_q <= sums;
    end
  end

  // the column index selects its sum from the snapshot
  assign res_data = sums_q[res_col];

endmodule

/* src/conv_core.sv */
module conv_core (
  input  logic                                  clkb,
  input  logic                                  reset,
  input  logic                                  wt_valid,
  input  logic [cnn_pkg::W_ADDR_WIDTH-1:0]      wt_addr,
  input  logic [cnn_pkg::WORD_WIDTH-1:0]        wt_data,
  input  logic                                  px_valid,
  input  logic signed [cnn_pkg::WORD_WIDTH-1:0] px_data,
  input  logic                                  px_last,
  output logic                                  res_valid,
  output logic [cnn_pkg::COL_WIDTH-1:0]         res_col,
  output logic signed [cnn_pkg::ACC_WIDTH-1:0]  res_data
);

  logic                             rd_en;
  logic [cnn_pkg::R_ADDR_WIDTH-1:0] rd_addr;
  logic [cnn_pkg::ROW_WIDTH-1:0]    rd_row;

  logic                                  mac_valid;
  logic signed [cnn_pkg::WORD_WIDTH-1:0] mac_pixel;
  logic                                  mac_last;

  logic [cnn_pkg::COLS-1:0]                         col_valid;
  logic [cnn_pkg::COLS-1:0][cnn_pkg::ACC_WIDTH-1:0] col_sums;

  ram_raw #(
    .LATENCY (cnn_pkg::LATENCY_BRAM)
  ) u_weights (
    .clkb    (clkb),
    .reset   (reset),
    .wr_en   (wt_valid),
    .wr_addr (wt_addr),
    .wr_data (wt_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_row  (rd_row)
  );

  mac_feeder u_feeder (
    .clkb      (clkb),
    .reset     (reset),
    .px_valid  (px_valid),
    .px_data   (px_data),
    .px_last   (px_last),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .mac_valid (mac_valid),
    .mac_pixel (mac_pixel),
    .mac_last  (mac_last)
  );

  // each element takes its own slice of the weight row
  for (genvar c = 0; c < cnn_pkg::COLS; c++) begin : g_col
    mac_pe u_pe (
      .clkb      (clkb),
      .reset     (reset),
      .mac_valid (mac_valid),
      .mac_last  (mac_last),
      .mac_pixel (mac_pixel),
      .weight    (rd_row[c*cnn_pkg::WORD_WIDTH +: cnn_pkg::WORD_WIDTH]),
      .sum_valid (col_valid[c]),
      .sum       (col_sums[c])
    );
  end

  // all elements fire together, column 0 stands for the rest
  result_drain u_drain (
    .clkb      (clkb),
    .reset     (reset),
    .sum_valid (col_valid[0]),
    .sums      (col_sums),
    .res_valid (res_valid),
    .res_col   (res_col),
    .res_data  (res_data)
  );

endmodule

/* sim/conv_core_tb.sv */
module conv_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string STIM_FILE   = "sim/conv_stim.txt";
  localparam int    RESULT_WAIT = 4 * (cnn_pkg::LATENCY_BRAM + cnn_pkg::COLS + 4);
  localparam int    SETTLE      = cnn_pkg::COLS + cnn_pkg::LATENCY_BRAM + 4;
  localparam int    MARGIN      = 100;

  logic                                  clkb;
  logic                                  reset;
  logic                                  wt_valid;
  logic [cnn_pkg::W_ADDR_WIDTH-1:0]      wt_addr;
  logic [cnn_pkg::WORD_WIDTH-1:0]        wt_data;
  logic                                  px_valid;
  logic signed [cnn_pkg::WORD_WIDTH-1:0] px_data;
  logic                                  px_last;
  logic                                  res_valid;
  logic [cnn_pkg::COL_WIDTH-1:0]         res_col;
  logic signed [cnn_pkg::ACC_WIDTH-1:0]  res_data;

  logic [cnn_pkg::COL_WIDTH-1:0]        exp_col[$];
  logic signed [cnn_pkg::ACC_WIDTH-1:0] exp_sum[$];
  logic [cnn_pkg::COL_WIDTH-1:0]        got_col[$];
  logic signed [cnn_pkg::ACC_WIDTH-1:0] got_sum[$];

  string cur_name;
  bit    test_open;
  int    test_err_base;
  int    err_count;
  int    tests_run;
  int    tests_failed;
  int    wd_cycles = 0;

  conv_core dut (
    .clkb      (clkb),
    .reset     (reset),
    .wt_valid  (wt_valid),
    .wt_addr   (wt_addr),
    .wt_data   (wt_data),
    .px_valid  (px_valid),
    .px_data   (px_data),
    .px_last   (px_last),
    .res_valid (res_valid),
    .res_col   (res_col),
    .res_data  (res_data)
  );

  initial begin
    clkb = 1'b0;
    forever #20 clkb = ~clkb;
  end

  // results are stable at the falling edge
  always @(negedge clkb) begin
    if (!reset && res_valid) begin
      got_col.push_back(res_col);
      got_sum.push_back(res_data);
    end
  end

  initial begin
    wait (wd_cycles > 0);
    #(wd_cycles * 40);
    $display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
    $display("Something failed");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string trim_text(input string s);
    int first;
    int last;
    first = 0;
    last  = s.len() - 1;
    while (first <= last && (s[first] == " " || s[first] == "\t")) begin
      first++;
    end
    while (last >= first && (s[last] == "\n" || s[last] == "\r" || s[last] == " ")) begin
      last--;
    end
    if (last < first) begin
      return "";
    end
    return s.substr(first, last);
  endfunction

  task automatic next_cycle();
    @(posedge clkb);
    #2;
  endtask

  task automatic write_weight(input logic [cnn_pkg::W_ADDR_WIDTH-1:0] addr,
                              input logic [cnn_pkg::WORD_WIDTH-1:0] data);
    wt_valid = 1'b1;
    wt_addr  = addr;
    wt_data  = data;
    next_cycle();
    wt_valid = 1'b0;
  endtask

  task automatic drive_pixel(input logic signed [cnn_pkg::WORD_WIDTH-1:0] data,
                             input logic last);
    px_valid = 1'b1;
    px_data  = data;
    px_last  = last;
    next_cycle();
    px_valid = 1'b0;
    px_last  = 1'b0;
  endtask

  task automatic check_col(input logic [cnn_pkg::COL_WIDTH-1:0] got,
                           input logic [cnn_pkg::COL_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL res_col got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic check_sum(input logic signed [cnn_pkg::ACC_WIDTH-1:0] got,
                           input logic signed [cnn_pkg::ACC_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("FAIL res_data got %h expected %h", got, exp);
      err_count++;
    end
  endtask

  task automatic start_test(input string name);
    cur_name      = name;
    test_open     = 1'b1;
    test_err_base = err_count;
  endtask

  // wait for the expected beats, then a few quiet cycles to catch extra ones
  task automatic finish_test();
    int waited;
    waited = 0;
    if (test_open) begin
      while (got_col.size() < exp_col.size() && waited < RESULT_WAIT) begin
        next_cycle();
        waited++;
      end
      repeat (SETTLE) next_cycle();
      if (got_col.size() < exp_col.size()) begin
        $display("test %s: only %0d of %0d results arrived", cur_name, got_col.size(),
                 exp_col.size());
        err_count++;
      end else if (got_col.size() > exp_col.size()) begin
        $display("test %s: %0d results arrived but %0d were expected", cur_name,
                 got_col.size(), exp_col.size());
        err_count++;
      end
      for (int i = 0; i < exp_col.size() && i < got_col.size(); i++) begin
        check_col(got_col[i], exp_col[i]);
        check_sum(got_sum[i], exp_sum[i]);
      end
      tests_run++;
      if (err_count == test_err_base) begin
        $display("test %s passed, %0d results", cur_name, exp_col.size());
      end else begin
        $display("test %s failed with %0d errors", cur_name, err_count - test_err_base);
        tests_failed++;
      end
      exp_col.delete();
      exp_sum.delete();
      got_col.delete();
      got_sum.delete();
      test_open = 1'b0;
    end
  endtask

  // rough cycle budget of the whole run, for the watchdog
  task automatic count_stim_cycles(output int cycles);
    int    fd;
    int    a;
    string line;
    cycles = MARGIN + 2 + cnn_pkg::W_DEPTH + cnn_pkg::WEIGHTS_DEPTH + RESULT_WAIT + SETTLE;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        line = trim_text(line);
        a = 0;
        if (line.len() > 0 && line[0] != "#") begin
          cycles++;
          if (line[0] == "I") begin
            void'($sscanf(line.substr(1, line.len() - 1), "%d", a));
            cycles += a;
          end else if (line[0] == "T") begin
            cycles += RESULT_WAIT + SETTLE;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_stim_file();
    int         fd;
    int         a;
    int         b;
    string      line;
    string      rest;
    logic [7:0] op;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      err_count++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        line = trim_text(line);
        if (line.len() > 0 && line[0] != "#") begin
          op   = line[0];
          rest = trim_text(line.substr(1, line.len() - 1));
          a    = 0;
          b    = 0;
          void'($sscanf(rest, "%d %d", a, b));
          case (op)
            "T": begin
              finish_test();
              start_test(rest);
            end
            "W": write_weight(cnn_pkg::W_ADDR_WIDTH'(a), cnn_pkg::WORD_WIDTH'(b));
            "P": drive_pixel(cnn_pkg::WORD_WIDTH'(a), b != 0);
            "I": repeat (a) next_cycle();
            "E": begin
              exp_col.push_back(cnn_pkg::COL_WIDTH'(a));
              exp_sum.push_back(cnn_pkg::ACC_WIDTH'(b));
            end
            default: begin
              $display("unknown line in the stimulus file: %s", line);
              err_count++;
            end
          endcase
        end
      end
      finish_test();
      $fclose(fd);
    end
  endtask

  // full-depth window, two rows and two pixels at full scale, the rest random
  task automatic run_random_test();
    logic [31:0]                           state;
    logic signed [cnn_pkg::WORD_WIDTH-1:0] wts[cnn_pkg::WEIGHTS_DEPTH][cnn_pkg::COLS];
    logic signed [cnn_pkg::WORD_WIDTH-1:0] pix[cnn_pkg::WEIGHTS_DEPTH];
    int                                    total;
    state = 32'h4ef3;
    for (int r = 0; r < cnn_pkg::WEIGHTS_DEPTH; r++) begin
      for (int c = 0; c < cnn_pkg::COLS; c++) begin
        state     = lcg_next(state);
        wts[r][c] = state[23:16];
      end
      state  = lcg_next(state);
      pix[r] = state[23:16];
    end
    for (int c = 0; c < cnn_pkg::COLS; c++) begin
      wts[0][c] = 8'sh80;
      wts[1][c] = (c % 2 == 0) ? 8'sh7f : 8'sh80;
    end
    pix[0] = 8'sh80;
    pix[1] = 8'sh7f;
    start_test("random_full_depth");
    for (int r = 0; r < cnn_pkg::WEIGHTS_DEPTH; r++) begin
      for (int c = 0; c < cnn_pkg::COLS; c++) begin
        write_weight(cnn_pkg::W_ADDR_WIDTH'(r * cnn_pkg::COLS + c), wts[r][c]);
      end
    end
    for (int r = 0; r < cnn_pkg::WEIGHTS_DEPTH; r++) begin
      drive_pixel(pix[r], r == cnn_pkg::WEIGHTS_DEPTH - 1);
    end
    for (int c = 0; c < cnn_pkg::COLS; c++) begin
      total = 0;
      for (int r = 0; r < cnn_pkg::WEIGHTS_DEPTH; r++) begin
        total += int'(pix[r]) * int'(wts[r][c]);
      end
      exp_col.push_back(cnn_pkg::COL_WIDTH'(c));
      exp_sum.push_back(cnn_pkg::ACC_WIDTH'(total));
    end
    finish_test();
  endtask

  initial begin
    int budget;
    reset     = 1'b1;
    wt_valid  = 1'b0;
    wt_addr   = '0;
    wt_data   = '0;
    px_valid  = 1'b0;
    px_data   = '0;
    px_last   = 1'b0;
    test_open = 1'b0;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    count_stim_cycles(budget);
    wd_cycles = budget;
    repeat (2) @(posedge clkb);
    #2;
    reset = 1'b0;
    run_stim_file();
    run_random_test();
    $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
             err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* sim/conv_stim.txt */
# columns: W narrow_addr weight | P pixel last | I idle_cycles
# E column expected_sum | T test_name   (all numbers signed decimal)
T no_window_after_reset
I 12
T load_and_readback
W 0 1
W 1 2
W 2 3
W 3 4
W 4 -1
W 5 0
W 6 5
W 7 -2
W 8 3
W 9 -3
W 10 1
W 11 0
W 12 2
W 13 1
W 14 -4
W 15 6
P 10 0
P -5 0
P 7 0
P 3 1
E 0 42
E 1 2
E 2 0
E 3 68
T two_windows_back_to_back
W 16 4
W 17 -1
W 18 2
W 19 1
W 20 -2
W 21 3
W 22 0
W 23 5
P 1 0
P 2 0
P 3 0
P 4 0
P 5 0
P 6 1
P -1 0
P 2 0
P -3 0
P 4 1
E 0 24
E 1 10
E 2 10
E 3 59
E 0 -4
E 1 11
E 2 -12
E 3 16
T idle_gaps_in_window
P 10 0
I 3
P -5 0
I 1
P 7 0
I 5
P 3 1
E 0 42
E 1 2
E 2 0
E 3 68
T overwrite_one_weight
W 9 4
P 10 0
P -5 0
P 7 0
P 3 1
E 0 42
E 1 51
E 2 0
E 3 68

/* filelist.f */
src/cnn_pkg.sv
src/ram_raw.sv
src/mac_feeder.sv
src/mac_pe.sv
src/result_drain.sv
src/conv_core.sv
sim/conv_core_tb.sv

/* Makefile */
VERILATOR  := verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := conv_core_tb
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
PASS_MSG   := Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
